// ==== project.f ====
+incdir+include
src/usb_line_pkg.sv
src/usb_pkt_pkg.sv
src/usb_rx_line.sv
src/usb_rx_pid_token.sv
src/usb_rx_data.sv
src/usb_rx_check.sv
src/usb_fs_rx.sv
tests/usb_fs_rx_sva.sv
tests/usb_fs_rx_tb.sv

// ==== Bender.yml ====
package:
  name: usb_fs_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/usb_line_pkg.sv
      - src/usb_pkt_pkg.sv
      - src/usb_rx_line.sv
      - src/usb_rx_pid_token.sv
      - src/usb_rx_data.sv
      - src/usb_rx_check.sv
      - src/usb_fs_rx.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/usb_fs_rx_sva.sv
      - tests/usb_fs_rx_tb.sv

// ==== tests/usb_fs_rx_tb.sv ====
////////////////////
// testbench of the USB full-speed receiver: clock, reset, NRZI packet
// encoder, six packet tests, end of packet checks and timeout
////////////////////

`timescale 1ns/1ns

`include "usb_rx_consts.svh"

module usb_fs_rx_tb import usb_pkt_pkg::*; ();

  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY  = 2;
  localparam int NUM_TESTS    = 7;
  // longest packet with SYNC, stuffing, EOP and idle gap, in bit times
  localparam int MAX_PKT_BITS = 95;
  // four cycles per bit and a threefold margin over all tests
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * MAX_PKT_BITS * 4 * 3;
  localparam logic [1:0] SYM_J   = 2'b10;
  localparam logic [1:0] SYM_K   = 2'b01;
  localparam logic [1:0] SYM_SE0 = 2'b00;

  logic clk_i = 1'b0;
  logic rst_ni, link_reset_i, cfg_eop_single_bit_i, usb_dp_i, usb_dn_i, tx_en_i;
  logic bit_strobe_o, pkt_start_o, pkt_end_o, rx_data_put_o;
  logic valid_pid_o, valid_packet_o;
  logic crc5_error_o, crc16_error_o, pid_error_o, bitstuff_error_o;
  pid_t       pid_o;
  addr_t      addr_o;
  endp_t      endp_o;
  frame_num_t frame_num_o;
  byte_t      rx_data_o;

  logic [31:0] rng_state;
  logic [1:0]  line_sym;
  bit          tx_bits[$];
  byte_t       rx_bytes[$];
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned test_count = 0;
  int unsigned end_count = 0;
  int unsigned start_count = 0;
  int unsigned end_starts = 0;
  int unsigned strobe_gap = 0;
  bit          strobe_seen = 1'b0;

  // outputs captured in the end of packet cycle
  logic end_valid, end_valid_pid, end_crc5_err, end_crc16_err, end_pid_err, end_stuff_err;
  pid_t       end_pid;
  addr_t      end_addr;
  endp_t      end_endp;
  frame_num_t end_frame;

  usb_fs_rx usb_fs_rx_inst (.*);

  always #CLK_HALF clk_i = ~clk_i;

  ////////////////////
  // monitor
  ////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      strobe_gap++;
      // every bit lasts four clocks, so the phase 2 strobe repeats every four
      if (bit_strobe_o) begin
        if (strobe_seen) begin
          expect_value("bit_strobe_o spacing in cycles", strobe_gap, 4);
        end
        strobe_seen = 1'b1;
        strobe_gap  = 0;
      end
    end
    if (rst_ni && pkt_start_o) begin
      start_count++;
    end
    if (rst_ni && rx_data_put_o) begin
      rx_bytes.push_back(rx_data_o);
    end
    if (rst_ni && pkt_end_o) begin
      end_count++;
      end_starts    = start_count;
      start_count   = 0;
      end_valid     = valid_packet_o;
      end_valid_pid = valid_pid_o;
      end_crc5_err  = crc5_error_o;
      end_crc16_err = crc16_error_o;
      end_pid_err   = pid_error_o;
      end_stuff_err = bitstuff_error_o;
      end_pid       = pid_o;
      end_addr      = addr_o;
      end_endp      = endp_o;
      end_frame     = frame_num_o;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // the upper nibble of a PID byte is the complement of the lower one
  function automatic byte_t pid_byte(input logic [3:0] p);
    return {~p, p};
  endfunction

  // CRC5 over the token field as sent, inverted for transmission
  function automatic logic [4:0] crc5_of(input logic [10:0] field);
    logic [4:0] c;
    logic       fb;
    int         i;
    c = 5'h1f;
    for (i = 0; i < 11; i++) begin
      fb = field[i] ^ c[4];
      c  = {c[3:0], 1'b0} ^ ({5{fb}} & `USB_CRC5_POLY);
    end
    return ~c;
  endfunction

  function automatic logic [15:0] crc16_of(input byte_t data[$]);
    logic [15:0] c;
    logic        fb;
    int          i, k;
    c = 16'hffff;
    for (i = 0; i < data.size(); i++) begin
      for (k = 0; k < 8; k++) begin
        fb = data[i][k] ^ c[15];
        c  = {c[14:0], 1'b0} ^ ({16{fb}} & `USB_CRC16_POLY);
      end
    end
    return ~c;
  endfunction

  // a CRC byte goes out MSB first but is collected LSB first
  function automatic byte_t reverse_bits(input byte_t v);
    byte_t r;
    int    i;
    for (i = 0; i < 8; i++) begin
      r[i] = v[7 - i];
    end
    return r;
  endfunction

  task automatic push_lsb(input logic [15:0] v, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      tx_bits.push_back(v[i]);
    end
  endtask

  task automatic push_msb(input logic [15:0] v, input int n);
    int i;
    for (i = n - 1; i >= 0; i--) begin
      tx_bits.push_back(v[i]);
    end
  endtask

  // entered and left a small delay after a rising edge
  task automatic drive_symbol(input logic [1:0] sym);
    {usb_dp_i, usb_dn_i} = sym;
    repeat (4) @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // NRZI, a zero toggles the line and a one keeps it
  task automatic send_nrzi(input bit b);
    if (!b) begin
      line_sym = (line_sym == SYM_J) ? SYM_K : SYM_J;
    end
    drive_symbol(line_sym);
  endtask

  // SYNC, the queued bits with optional stuffing, EOP and an idle gap
  task automatic send_packet(input bit stuff_en, input bit single_se0);
    int ones;
    ones = 0;
    line_sym = SYM_J;
    repeat (7) send_nrzi(1'b0);
    send_nrzi(1'b1);
    foreach (tx_bits[i]) begin
      send_nrzi(tx_bits[i]);
      ones = tx_bits[i] ? ones + 1 : 0;
      if (stuff_en && ones == `USB_STUFF_LIMIT) begin
        send_nrzi(1'b0);
        ones = 0;
      end
    end
    drive_symbol(SYM_SE0);
    if (!single_se0) begin
      drive_symbol(SYM_SE0);
    end
    line_sym = SYM_J;
    repeat (5) drive_symbol(SYM_J);
  endtask

  task automatic wait_packet_end(input int unsigned ends_before);
    int waited;
    waited = 0;
    while (end_count == ends_before && waited < 40) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      waited++;
    end
    if (end_count == ends_before) begin
      $display("no end of packet seen within 40 cycles after the EOP");
      errors++;
    end else begin
      expect_value("pkt_start_o pulses before pkt_end_o", end_starts, 1);
    end
  endtask

  task automatic expect_value(input string what, input int unsigned got,
                              input int unsigned exp);
    checks++;
    assert (got == exp)
      else begin
        errors++;
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
  endtask

  task automatic report_test(input string name, input int unsigned err_start);
    test_count++;
    if (errors == err_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d mismatches", test_count, name, errors - err_start);
    end
  endtask

  ////////////////////
  // stimulus and checks
  ////////////////////

  initial begin
    int unsigned err_start, ends_before;
    logic [10:0] field;
    logic [4:0]  crc5;
    logic [15:0] crc16;
    byte_t       payload[$];
    byte_t       expected[$];
    int          i;

    rst_ni               = 1'b0;
    link_reset_i         = 1'b0;
    tx_en_i              = 1'b0;
    cfg_eop_single_bit_i = 1'b0;
    usb_dp_i             = 1'b1;
    usb_dn_i             = 1'b0;
    rng_state            = 32'h43395e47;
    line_sym             = SYM_J;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;

    err_start = errors;
    expect_value("addr_o after reset", addr_o, 0);
    expect_value("endp_o after reset", endp_o, 0);
    expect_value("frame_num_o after reset", frame_num_o, 0);
    expect_value("error outputs after reset",
                 {crc5_error_o, crc16_error_o, pid_error_o, bitstuff_error_o}, 0);
    report_test("reset values", err_start);
    repeat (3) drive_symbol(SYM_J);

    // OUT token, address in field bits 0..6 and endpoint in 7..10
    err_start = errors;
    rng_state = xorshift32(rng_state);
    field = rng_state[10:0];
    crc5 = crc5_of(field);
    tx_bits.delete();
    push_lsb(pid_byte(PID_OUT), 8);
    push_lsb(field, 11);
    push_msb(crc5, 5);
    ends_before = end_count;
    send_packet(1'b1, 1'b0);
    wait_packet_end(ends_before);
    expect_value("valid_packet_o", end_valid, 1);
    expect_value("pid_o", end_pid, PID_OUT);
    expect_value("addr_o", end_addr, field[6:0]);
    expect_value("endp_o", end_endp, field[10:7]);
    expect_value("frame_num_o", end_frame, field);
    expect_value("error pulses",
                 {end_crc5_err, end_crc16_err, end_pid_err, end_stuff_err}, 0);
    report_test("OUT token", err_start);

    // DATA0 with four random bytes, the CRC16 bytes are delivered too
    err_start = errors;
    payload.delete();
    for (i = 0; i < 4; i++) begin
      rng_state = xorshift32(rng_state);
      payload.push_back(rng_state[7:0]);
    end
    crc16 = crc16_of(payload);
    expected = payload;
    expected.push_back(reverse_bits(crc16[15:8]));
    expected.push_back(reverse_bits(crc16[7:0]));
    tx_bits.delete();
    push_lsb(pid_byte(PID_DATA0), 8);
    foreach (payload[k]) begin
      push_lsb(payload[k], 8);
    end
    push_msb(crc16, 16);
    rx_bytes.delete();
    ends_before = end_count;
    send_packet(1'b1, 1'b0);
    wait_packet_end(ends_before);
    expect_value("rx_data_put_o pulses", rx_bytes.size(), 6);
    for (i = 0; i < expected.size() && i < rx_bytes.size(); i++) begin
      expect_value($sformatf("rx_data_o byte %0d", i), rx_bytes[i], expected[i]);
    end
    expect_value("valid_packet_o", end_valid, 1);
    expect_value("crc16_error_o", end_crc16_err, 0);
    report_test("DATA0 packet", err_start);

    // IN token whose CRC5 has bit 2 flipped
    err_start = errors;
    rng_state = xorshift32(rng_state);
    field = rng_state[10:0];
    crc5 = crc5_of(field) ^ 5'b00100;
    tx_bits.delete();
    push_lsb(pid_byte(PID_IN), 8);
    push_lsb(field, 11);
    push_msb(crc5, 5);
    ends_before = end_count;
    send_packet(1'b1, 1'b0);
    wait_packet_end(ends_before);
    expect_value("crc5_error_o", end_crc5_err, 1);
    expect_value("valid_packet_o", end_valid, 0);
    report_test("CRC5 error", err_start);

    // nibbles equal instead of complementary
    err_start = errors;
    tx_bits.delete();
    push_lsb(8'h22, 8);
    ends_before = end_count;
    send_packet(1'b1, 1'b0);
    wait_packet_end(ends_before);
    expect_value("pid_error_o", end_pid_err, 1);
    expect_value("valid_pid_o", end_valid_pid, 0);
    expect_value("valid_packet_o", end_valid, 0);
    report_test("PID error", err_start);

    // eight ones sent without the stuffed zero
    err_start = errors;
    tx_bits.delete();
    push_lsb(pid_byte(PID_DATA0), 8);
    push_lsb(8'hff, 8);
    ends_before = end_count;
    send_packet(1'b0, 1'b0);
    wait_packet_end(ends_before);
    expect_value("bitstuff_error_o", end_stuff_err, 1);
    expect_value("valid_packet_o", end_valid, 0);
    report_test("bitstuff error", err_start);

    // ACK ended by a single SE0 bit
    err_start = errors;
    cfg_eop_single_bit_i = 1'b1;
    tx_bits.delete();
    push_lsb(pid_byte(PID_ACK), 8);
    ends_before = end_count;
    send_packet(1'b1, 1'b1);
    wait_packet_end(ends_before);
    cfg_eop_single_bit_i = 1'b0;
    expect_value("valid_packet_o", end_valid, 1);
    expect_value("pid_o", end_pid, PID_ACK);
    report_test("ACK single SE0", err_start);

    errors += usb_fs_rx_inst.sva_inst.violations;
    $display("tests: %0d, checks: %0d, errors: %0d", test_count, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    int unsigned cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== tests/usb_fs_rx_sva.sv ====
////////////////////
// protocol assertions on the receiver ports, bound to the top level
////////////////////

`timescale 1ns/1ns

module usb_fs_rx_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic pkt_start_i,
  input logic pkt_end_i,
  input logic rx_data_put_i,
  input logic crc5_error_i,
  input logic crc16_error_i,
  input logic pid_error_i,
  input logic bitstuff_error_i
);

  // failed assertions are tallied here, the testbench reads the tally
  int unsigned violations = 0;
  logic        in_pkt_q;
  logic        any_error;

  assign any_error = crc5_error_i | crc16_error_i | pid_error_i | bitstuff_error_i;

  // high from the cycle after the start pulse up to the end pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_pkt_q <= 1'b0;
    end else if (pkt_start_i) begin
      in_pkt_q <= 1'b1;
    end else if (pkt_end_i) begin
      in_pkt_q <= 1'b0;
    end
  end

  end_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pkt_end_i |=> !pkt_end_i)
    else begin
      $error("pkt_end_o stayed high for more than one cycle");
      violations++;
    end

  // every error output is a strobe of the end of packet cycle
  error_at_end_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_error |-> pkt_end_i)
    else begin
      $error("an error output pulsed outside the end of packet cycle");
      violations++;
    end

  put_in_pkt_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_data_put_i |-> in_pkt_q)
    else begin
      $error("rx_data_put_o pulsed outside a packet");
      violations++;
    end

endmodule

bind usb_fs_rx usb_fs_rx_sva sva_inst (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .pkt_start_i      (pkt_start_o),
  .pkt_end_i        (pkt_end_o),
  .rx_data_put_i    (rx_data_put_o),
  .crc5_error_i     (crc5_error_o),
  .crc16_error_i    (crc16_error_o),
  .pid_error_i      (pid_error_o),
  .bitstuff_error_i (bitstuff_error_o)
);

// ==== src/usb_fs_rx.sv ====
////////////////////
// USB full-speed packet receiver, top level
////////////////////

`timescale 1ns/1ns

module usb_fs_rx import usb_pkt_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       cfg_eop_single_bit_i,
  input  logic       usb_dp_i,
  input  logic       usb_dn_i,
  input  logic       tx_en_i,
  output logic       bit_strobe_o,
  output logic       pkt_start_o,
  output logic       pkt_end_o,
  output pid_t       pid_o,
  output addr_t      addr_o,
  output endp_t      endp_o,
  output frame_num_t frame_num_o,
  output logic       rx_data_put_o,
  output byte_t      rx_data_o,
  output logic       valid_pid_o,
  output logic       valid_packet_o,
  output logic       crc5_error_o,
  output logic       crc16_error_o,
  output logic       pid_error_o,
  output logic       bitstuff_error_o
);

  // decoded bit stream shared by the PID/token and data paths
  logic       rx_bit, rx_bit_valid, stuff_err;
  logic       pid_done, pid_ok, crc5_ok;
  pkt_kind_e  kind;
  logic       byte_strobe, crc16_ok;
  byte_t      rx_byte;
  logic [4:0] len;

  usb_rx_line line_inst (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .link_reset_i         (link_reset_i),
    .tx_en_i              (tx_en_i),
    .cfg_eop_single_bit_i (cfg_eop_single_bit_i),
    .usb_dp_i             (usb_dp_i),
    .usb_dn_i             (usb_dn_i),
    .bit_strobe_o         (bit_strobe_o),
    .bit_o                (rx_bit),
    .bit_valid_o          (rx_bit_valid),
    .pkt_start_o          (pkt_start_o),
    .pkt_end_o            (pkt_end_o),
    .stuff_err_o          (stuff_err)
  );

  usb_rx_pid_token pid_token_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .bit_i        (rx_bit),
    .bit_valid_i  (rx_bit_valid),
    .pkt_start_i  (pkt_start_o),
    .pid_o        (pid_o),
    .pid_done_o   (pid_done),
    .pid_ok_o     (pid_ok),
    .crc5_ok_o    (crc5_ok),
    .kind_o       (kind),
    .addr_o       (addr_o),
    .endp_o       (endp_o),
    .frame_num_o  (frame_num_o)
  );

  usb_rx_data data_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .bit_i         (rx_bit),
    .bit_valid_i   (rx_bit_valid),
    .pkt_start_i   (pkt_start_o),
    .pid_done_i    (pid_done),
    .byte_strobe_o (byte_strobe),
    .byte_o        (rx_byte),
    .crc16_ok_o    (crc16_ok),
    .len_o         (len)
  );

  usb_rx_check check_inst (
    .pkt_end_i        (pkt_end_o),
    .stuff_err_i      (stuff_err),
    .pid_ok_i         (pid_ok),
    .kind_i           (kind),
    .crc5_ok_i        (crc5_ok),
    .crc16_ok_i       (crc16_ok),
    .len_i            (len),
    .byte_strobe_i    (byte_strobe),
    .byte_i           (rx_byte),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o),
    .rx_data_put_o    (rx_data_put_o),
    .rx_data_o        (rx_data_o)
  );

endmodule

// ==== src/usb_rx_check.sv ====
////////////////////
// packet checker: validity, error pulses and data strobe
////////////////////

`timescale 1ns/1ns

module usb_rx_check import usb_pkt_pkg::*; (
  input  logic       pkt_end_i,
  input  logic       stuff_err_i,
  input  logic       pid_ok_i,
  input  pkt_kind_e  kind_i,
  input  logic       crc5_ok_i,
  input  logic       crc16_ok_i,
  input  logic [4:0] len_i,
  input  logic       byte_strobe_i,
  input  byte_t      byte_i,
  output logic       valid_pid_o,
  output logic       valid_packet_o,
  output logic       crc5_error_o,
  output logic       crc16_error_o,
  output logic       pid_error_o,
  output logic       bitstuff_error_o,
  output logic       rx_data_put_o,
  output byte_t      rx_data_o
);

  logic is_token, is_data, is_handshake;
  logic hs_len_ok, token_len_ok, data_len_ok;

  assign is_token     = (kind_i == KIND_TOKEN);
  assign is_data      = (kind_i == KIND_DATA);
  assign is_handshake = (kind_i == KIND_HANDSHAKE);

  // a handshake carries nothing after the PID and a token sixteen bits
  assign hs_len_ok    = (len_i == 5'd0);
  assign token_len_ok = (len_i == 5'b10000);
  // data holds at least the CRC16 and ends on a byte boundary
  assign data_len_ok  = len_i[4] && (len_i[2:0] == 3'd0);

  assign valid_pid_o    = pid_ok_i;
  assign valid_packet_o = pid_ok_i && !stuff_err_i &&
                          ((is_handshake && hs_len_ok) ||
                           (is_token && token_len_ok && crc5_ok_i) ||
                           (is_data && data_len_ok && crc16_ok_i));

  // errors are reported once, in the end of packet cycle
  assign crc5_error_o     = pkt_end_i && is_token && !crc5_ok_i;
  assign crc16_error_o    = pkt_end_i && is_data && !crc16_ok_i;
  assign pid_error_o      = pkt_end_i && !pid_ok_i;
  assign bitstuff_error_o = pkt_end_i && stuff_err_i;

  // tokens and handshakes are deserialized too but never reach the user
  assign rx_data_put_o = byte_strobe_i && is_data;
  assign rx_data_o     = byte_i;

endmodule

// ==== src/usb_rx_data.sv ====
////////////////////
// byte deserializer, CRC16 and bit length count after the PID
////////////////////

`timescale 1ns/1ns

`include "usb_rx_consts.svh"

module usb_rx_data import usb_pkt_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       bit_i,
  input  logic       bit_valid_i,
  input  logic       pkt_start_i,
  input  logic       pid_done_i,
  output logic       byte_strobe_o,
  output byte_t      byte_o,
  output logic       crc16_ok_o,
  output logic [4:0] len_o
);

  logic [8:0] byte_sr_q;
  logic       byte_full, post_pid_bit, crc16_fb;
  crc16_t     crc16_q;
  logic [3:0] len_q;
  logic       len16_q;

  // the sentinel reaches bit 0 with the eighth bit, the byte is offered
  // for that one cycle and the register restarts
  assign byte_full     = byte_sr_q[0];
  assign byte_strobe_o = byte_full;
  assign byte_o        = byte_sr_q[8:1];

  assign post_pid_bit = bit_valid_i && pid_done_i;
  assign crc16_fb     = bit_i ^ crc16_q[15];
  assign crc16_ok_o   = (crc16_q == `USB_CRC16_RESIDUE);

  // count modulo sixteen plus a sticky flag once sixteen bits are in
  assign len_o = {len16_q, len_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_sr_q <= 9'b100000000;
      crc16_q   <= '1;
      len_q     <= '0;
      len16_q   <= 1'b0;
    end else if (link_reset_i || pkt_start_i) begin
      byte_sr_q <= 9'b100000000;
      crc16_q   <= '1;
      len_q     <= '0;
      len16_q   <= 1'b0;
    end else begin
      // bits are four clocks apart so a full byte never meets a new bit
      if (byte_full) begin
        byte_sr_q <= 9'b100000000;
      end else if (post_pid_bit) begin
        byte_sr_q <= {bit_i, byte_sr_q[8:1]};
      end
      if (post_pid_bit) begin
        crc16_q <= {crc16_q[14:0], 1'b0} ^ ({16{crc16_fb}} & `USB_CRC16_POLY);
        len16_q <= len16_q | (&len_q);
        len_q   <= len_q + 4'd1;
      end
    end
  end

endmodule

// ==== src/usb_rx_pid_token.sv ====
////////////////////
// PID capture and check, packet kind, CRC5 and token fields
////////////////////

`timescale 1ns/1ns

`include "usb_rx_consts.svh"

module usb_rx_pid_token import usb_pkt_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       bit_i,
  input  logic       bit_valid_i,
  input  logic       pkt_start_i,
  output pid_t       pid_o,
  output logic       pid_done_o,
  output logic       pid_ok_o,
  output logic       crc5_ok_o,
  output pkt_kind_e  kind_o,
  output addr_t      addr_o,
  output endp_t      endp_o,
  output frame_num_t frame_num_o
);

  // bits arrive LSB first behind a sentinel, it lands in bit 0 once the
  // whole PID byte is in
  logic [8:0] pid_sr_q;
  logic [`USB_TOKEN_BITS:0] tok_sr_q;
  logic       pid_done, tok_done, post_pid_bit, crc5_fb;
  pkt_kind_e  kind;
  crc5_t      crc5_q;

  assign pid_done     = pid_sr_q[0];
  assign tok_done     = tok_sr_q[0];
  assign post_pid_bit = bit_valid_i && pid_done;
  assign crc5_fb      = bit_i ^ crc5_q[4];
  assign kind         = pkt_kind_e'(pid_sr_q[2:1]);

  // the upper nibble must be the complement of the PID itself
  assign pid_o      = pid_sr_q[4:1];
  assign pid_done_o = pid_done;
  assign pid_ok_o   = pid_done && (pid_sr_q[4:1] == ~pid_sr_q[8:5]);
  assign kind_o     = kind;
  assign crc5_ok_o  = (crc5_q == `USB_CRC5_RESIDUE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_sr_q <= 9'b100000000;
      crc5_q   <= '1;
      tok_sr_q <= {1'b1, {`USB_TOKEN_BITS{1'b0}}};
    end else if (link_reset_i || pkt_start_i) begin
      pid_sr_q <= 9'b100000000;
      crc5_q   <= '1;
      tok_sr_q <= {1'b1, {`USB_TOKEN_BITS{1'b0}}};
    end else begin
      if (bit_valid_i && !pid_done) begin
        pid_sr_q <= {bit_i, pid_sr_q[8:1]};
      end
      // CRC5 runs over every bit after the PID, CRC bits included
      if (post_pid_bit) begin
        crc5_q <= {crc5_q[3:0], 1'b0} ^ ({5{crc5_fb}} & `USB_CRC5_POLY);
      end
      if (post_pid_bit && kind == KIND_TOKEN && !tok_done) begin
        tok_sr_q <= {bit_i, tok_sr_q[`USB_TOKEN_BITS:1]};
      end
    end
  end

  // address is token bits 0 to 6, endpoint bits 7 to 10, an SOF uses
  // all eleven as the frame number
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_o      <= '0;
      endp_o      <= '0;
      frame_num_o <= '0;
    end else if (link_reset_i) begin
      addr_o      <= '0;
      endp_o      <= '0;
      frame_num_o <= '0;
    end else if (tok_done && kind == KIND_TOKEN) begin
      addr_o      <= tok_sr_q[7:1];
      endp_o      <= tok_sr_q[11:8];
      frame_num_o <= tok_sr_q[11:1];
    end
  end

endmodule

// ==== src/usb_rx_line.sv ====
////////////////////
// USB receive front end: line state recovery, clock recovery,
// SYNC and EOP framing, NRZI decode and bit unstuffing
////////////////////

`timescale 1ns/1ns

`include "usb_rx_consts.svh"

module usb_rx_line import usb_line_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic tx_en_i,
  input  logic cfg_eop_single_bit_i,
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  output logic bit_strobe_o,
  output logic bit_o,
  output logic bit_valid_o,
  output logic pkt_start_o,
  output logic pkt_end_o,
  output logic stuff_err_o
);

  ////////////////////
  // line state recovery
  ////////////////////

  logic [1:0]  dpair;
  line_state_e pair_state;
  line_state_e line_state_q, line_state_d;

  // while transmitting the receiver sees an idle J line
  assign dpair = tx_en_i ? 2'b10 : {usb_dp_i, usb_dn_i};

  // an illegal SE1 is taken as SE0 so that it ends a packet
  always_comb begin
    case (dpair)
      2'b10:   pair_state = LS_J;
      2'b01:   pair_state = LS_K;
      default: pair_state = LS_SE0;
    endcase
  end

  // a change on the pair first goes through the transition state, the
  // new symbol is taken one cycle later when both wires have settled
  always_comb begin
    line_state_d = line_state_q;
    if (line_state_q == LS_TRANS) begin
      line_state_d = pair_state;
    end else if (pair_state != line_state_q) begin
      line_state_d = LS_TRANS;
    end
  end

  ////////////////////
  // clock recovery
  ////////////////////

  bit_phase_t bit_phase_q;
  logic       sample_en;

  // the symbol is sampled mid-bit, the phase restarts on every transition
  assign sample_en    = (bit_phase_q == 2'd1);
  assign bit_strobe_o = (bit_phase_q == 2'd2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_state_q <= LS_SE0;
      bit_phase_q  <= '0;
    end else if (link_reset_i) begin
      line_state_q <= LS_SE0;
      bit_phase_q  <= '0;
    end else begin
      line_state_q <= line_state_d;
      bit_phase_q  <= (line_state_q == LS_TRANS) ? '0 : bit_phase_q + 2'd1;
    end
  end

  ////////////////////
  // packet framing
  ////////////////////

  logic [11:0] line_hist_q;
  logic        pkt_active_q, pkt_active_d;
  logic        see_eop;
  logic        stuff_err_q;

  // an EOP is one or two sampled SE0 symbols, a stuffing error also ends
  // the packet at the next sample
  assign see_eop = (cfg_eop_single_bit_i && line_hist_q[1:0] == 2'b00) ||
                   (line_hist_q[3:0] == 4'b0000) || stuff_err_q;

  always_comb begin
    pkt_active_d = pkt_active_q;
    if (sample_en) begin
      if (!pkt_active_q && line_hist_q == `USB_SYNC_HISTORY) begin
        pkt_active_d = 1'b1;
      end else if (pkt_active_q && see_eop) begin
        pkt_active_d = 1'b0;
      end
    end
  end

  // start pulses as the PID begins, not at the first SYNC edge
  assign pkt_start_o = pkt_active_d & ~pkt_active_q;
  assign pkt_end_o   = ~pkt_active_d & pkt_active_q;

  // the history starts as an idle J line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_hist_q  <= 12'b101010101010;
      pkt_active_q <= 1'b0;
    end else if (link_reset_i) begin
      line_hist_q  <= 12'b101010101010;
      pkt_active_q <= 1'b0;
    end else begin
      if (sample_en) begin
        line_hist_q <= {line_hist_q[9:0], line_state_q[1:0]};
      end
      pkt_active_q <= pkt_active_d;
    end
  end

  ////////////////////
  // NRZI decode and unstuffing
  ////////////////////

  logic din, sym_ok, dvalid_raw;
  logic [`USB_STUFF_LIMIT-1:0] ones_q;
  logic stuff_full;

  // an unchanged symbol is a one, a J/K change is a zero
  always_comb begin
    unique case (line_hist_q[3:0])
      4'b0101, 4'b1010: begin
        din    = 1'b1;
        sym_ok = 1'b1;
      end
      4'b0110, 4'b1001: begin
        din    = 1'b0;
        sym_ok = 1'b1;
      end
      default: begin
        din    = 1'b0;
        sym_ok = 1'b0;
      end
    endcase
  end

  assign dvalid_raw = pkt_active_q && sample_en && sym_ok;
  assign stuff_full = &ones_q;

  // the zero after six ones is dropped, a seventh one is an error
  assign bit_o       = din;
  assign bit_valid_o = dvalid_raw && !stuff_full;
  assign stuff_err_o = stuff_err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ones_q      <= '0;
      stuff_err_q <= 1'b0;
    end else if (link_reset_i) begin
      ones_q      <= '0;
      stuff_err_q <= 1'b0;
    end else begin
      if (pkt_end_o) begin
        ones_q <= '0;
      end else if (dvalid_raw) begin
        ones_q <= {ones_q[`USB_STUFF_LIMIT-2:0], din};
      end
      if (pkt_start_o) begin
        stuff_err_q <= 1'b0;
      end else if (dvalid_raw && stuff_full && din) begin
        stuff_err_q <= 1'b1;
      end
    end
  end

endmodule

// ==== src/usb_pkt_pkg.sv ====
////////////////////
// packet level types of the USB receiver: PID codes,
// packet kinds, token fields, data bytes and CRC registers
////////////////////

package usb_pkt_pkg;

  typedef logic [3:0] pid_t;

  // the lower two PID bits give the packet kind
  typedef enum logic [3:0] {
    PID_RSVD  = 4'b0000,
    PID_OUT   = 4'b0001,
    PID_ACK   = 4'b0010,
    PID_DATA0 = 4'b0011,
    PID_PING  = 4'b0100,
    PID_SOF   = 4'b0101,
    PID_NYET  = 4'b0110,
    PID_DATA2 = 4'b0111,
    PID_SPLIT = 4'b1000,
    PID_IN    = 4'b1001,
    PID_NAK   = 4'b1010,
    PID_DATA1 = 4'b1011,
    PID_PRE   = 4'b1100,
    PID_SETUP = 4'b1101,
    PID_STALL = 4'b1110,
    PID_MDATA = 4'b1111
  } usb_pid_e;

  typedef enum logic [1:0] {
    KIND_SPECIAL   = 2'b00,
    KIND_TOKEN     = 2'b01,
    KIND_HANDSHAKE = 2'b10,
    KIND_DATA      = 2'b11
  } pkt_kind_e;

  typedef logic [6:0]  addr_t;
  typedef logic [3:0]  endp_t;
  typedef logic [10:0] frame_num_t;
  typedef logic [7:0]  byte_t;
  typedef logic [4:0]  crc5_t;
  typedef logic [15:0] crc16_t;

endpackage

// ==== src/usb_line_pkg.sv ====
////////////////////
// line level types of the USB receiver: line symbols and
// the sample position inside a bit
////////////////////

package usb_line_pkg;

  // symbols seen on the D+/D- pair, the lower two bits are {D+, D-}
  // the transition state marks a sample where the pair may be skewed
  typedef enum logic [2:0] {
    LS_SE0   = 3'b000,
    LS_K     = 3'b001,
    LS_J     = 3'b010,
    LS_TRANS = 3'b100
  } line_state_e;

  // four samples per bit, phase 0 follows a recovered transition
  typedef logic [1:0] bit_phase_t;

endpackage

// ==== include/usb_rx_consts.svh ====
////////////////////
// constants of the USB full-speed receiver: CRC polynomials and
// residues, the SYNC history pattern and the bit stuffing limit
////////////////////

`ifndef USB_RX_CONSTS_SVH
`define USB_RX_CONSTS_SVH

// CRC5 covers the eleven token bits, x^5 + x^2 + 1
`define USB_CRC5_POLY 5'b00101
// remainder left in the CRC5 register when the received CRC is correct
`define USB_CRC5_RESIDUE 5'b01100

// CRC16 covers the data payload, x^16 + x^15 + x^2 + 1
`define USB_CRC16_POLY 16'b1000000000000101
// remainder left in the CRC16 register when the received CRC is correct
`define USB_CRC16_RESIDUE 16'b1000000000001101

// last six sampled symbols of SYNC, K J K J K K, two bits per symbol
`define USB_SYNC_HISTORY 12'b011001100101

// six ones in a row are followed by a stuffed zero on the wire
`define USB_STUFF_LIMIT 6

// address plus endpoint, or the frame number, in a token
`define USB_TOKEN_BITS 11

`endif
